/* verification/a53_input.txt */
# columns: kind then hex fields. w addr data, p cpu_addr prg_addr, c ppu_addr chr_addr a10
# a ss_addr data, r ss_addr rdata, s ss_act, m addr data srm_addr
p 8000 78000
p c000 7c000
p e456 7e456
c 2400 0400 1
m 6000 55 0000
m 7abc a5 1abc
w 5000 80
w 8000 1e
w 5000 01
w 8000 05
p 8000 78000
p c000 74000
w 5000 81
w 8000 0a
p 8000 50000
p c000 54000
w 5000 80
w 8000 2b
w 5000 01
w 8000 02
p a123 4a123
p c000 54000
c 0800 0800 1
c 0400 0400 0
w 5000 00
w 8000 13
c 1abc 7abc 1
c 1400 7400 0
w 5000 80
w 8000 2a
c 0400 6400 1
c 0800 6800 0
w 8000 28
w 5000 00
w 8000 11
c 0000 2000 1
w 8000 01
c 0c00 2c00 0
w 5000 01
w 8000 12
c 0c00 2c00 1
r 0 02
r 1 0a
r 2 99
r 3 01
r 7f 5a
r 10 ff
a 0 0d
a 1 3e
a 2 ec
a 3 02
p 8000 70000
p c000 74000
c 0400 4400 1
r 0 0d
r 1 3e
r 2 ec
r 3 02
s 1
w 5000 81
w 8000 00
s 0
r 2 ec
r 3 02
p c000 74000
w 8000 03
c 0400 6400 1

/* build.f */
hdl/a53_pkg.sv
hdl/a53_regs.sv
hdl/prg_window.sv
hdl/a53_addr_mux.sv
hdl/ss_axil_slave.sv
hdl/a53_mapper.sv
verification/a53_mapper_assert.sv
verification/tb_a53_mapper.sv

/* Bender.yml */
package:
  name: a53_mapper

sources:
  - hdl/a53_pkg.sv
  - hdl/a53_regs.sv
  - hdl/prg_window.sv
  - hdl/a53_addr_mux.sv
  - hdl/ss_axil_slave.sv
  - hdl/a53_mapper.sv
  - target: test
    files:
      - verification/a53_mapper_assert.sv
      - verification/tb_a53_mapper.sv

/* verification/tb_a53_mapper.sv */
`timescale 1ns/1ps

module tb_a53_mapper;
	import a53_pkg::*;

	logic                m2;
	logic                map_rst;
	logic                ss_act;
	cpu_bus_t            cpu;
	ppu_bus_t            ppu;
	logic [7:0]          map_idx;
	logic [PRG_AW-1:0]   prg_addr;
	logic                prg_oe;
	logic                rom_ce;
	logic                ram_ce;
	logic                ram_we;
	logic [12:0]         srm_addr;
	logic [CHR_AW-1:0]   chr_addr;
	logic                chr_ce;
	logic                chr_we;
	logic                chr_oe;
	logic                ciram_a10;
	logic                ciram_ce;
	logic [31:0]         awaddr;
	logic                awvalid;
	logic                awready;
	logic [31:0]         wdata;
	logic [3:0]          wstrb;
	logic                wvalid;
	logic                wready;
	logic [1:0]          bresp;
	logic                bvalid;
	logic                bready;
	logic [31:0]         araddr;
	logic                arvalid;
	logic                arready;
	logic [31:0]         rdata;
	logic [1:0]          rresp;
	logic                rvalid;
	logic                rready;

	int                  err_cnt = 0;
	int                  n_lines = 0;
	logic [31:0]         rnd = 32'h6d6c;

	a53_mapper #(.n_win(2)) u_a53_mapper (.*);

	initial begin
		m2 = 1'b0;
		forever #50 m2 = ~m2;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// holds off a ready for 0 to 3 extra cycles.
	task automatic ready_delay();
		rnd = xorshift(rnd);
		repeat (rnd[1:0]) @(posedge m2);
		@(posedge m2);
		#5;
	endtask

	task automatic cpu_drive(input logic [15:0] a, input logic [7:0] d, input logic rw);
		@(posedge m2);
		#5;
		cpu.addr = a[14:0];
		cpu.ce   = !a[15]; // only $8000-$FFFF is rom space.
		cpu.dat  = d;
		cpu.rw   = rw;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		cpu_drive(a, d, 1'b0);
		@(posedge m2);
		#5;
		cpu.rw = 1'b1;
	endtask

	task automatic axi_write(input logic [7:0] a, input logic [7:0] d);
		@(posedge m2);
		#5;
		awaddr  = {22'd0, a, 2'b00};
		wdata   = {24'd0, d};
		wstrb   = 4'h1;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge m2);
		while (!awready) @(negedge m2);
		@(posedge m2);
		#5;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		@(negedge m2);
		check("bvalid", bvalid, 1);
		check("bresp", bresp, 0);
		ready_delay();
		bready = 1'b1;
		@(negedge m2);
		check("bvalid before bready", bvalid, 1);
		@(posedge m2);
		#5;
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] a, input logic [7:0] exp);
		@(posedge m2);
		#5;
		araddr  = {22'd0, a, 2'b00};
		arvalid = 1'b1;
		@(negedge m2);
		while (!arready) @(negedge m2);
		@(posedge m2);
		#5;
		arvalid = 1'b0;
		ready_delay();
		rready = 1'b1;
		@(negedge m2);
		check("rvalid", rvalid, 1);
		check("rdata", rdata, {24'd0, exp});
		check("rresp", rresp, 0);
		@(posedge m2);
		#5;
		rready = 1'b0;
	endtask

	// ----------------------
	// watchdog
	// ----------------------
	initial begin
		wait (n_lines > 0);
		repeat (n_lines * 20) @(posedge m2);
		$display("watchdog expired after %0d cycles", n_lines * 20);
		$display("** FAIL **");
		$fatal(1, "the run did not finish in time");
	end

	initial begin
		wait (u_a53_mapper.u_a53_mapper_assert.n_fail != 0);
		$display("a bound assertion on the DUT failed");
		$display("** FAIL **");
		$fatal(1, "assertion failure");
	end

	initial begin
		int          fd;
		int          n;
		string       kind;
		string       line;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;

		map_rst = 1'b1;
		ss_act  = 1'b0;
		cpu     = '{addr: 15'd0, dat: 8'd0, rw: 1'b1, ce: 1'b1};
		ppu     = '{addr: 14'd0, oe: 1'b1, we: 1'b1};
		map_idx = 8'h5a;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;

		fd = $fopen("verification/a53_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file verification/a53_input.txt");
			$display("** FAIL **");
			$fatal(1, "stimulus file missing");
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) > 0)
				n_lines++;
		end
		$fclose(fd);
		fd = $fopen("verification/a53_input.txt", "r");

		repeat (8) @(posedge m2);
		#5;
		map_rst = 1'b0;

		while ($fscanf(fd, "%s", kind) == 1) begin
			case (kind)
				"#": n = $fgets(line, fd); // column notes.
				"w": begin
					n = $fscanf(fd, "%h %h", f0, f1);
					cpu_write(f0[15:0], f1[7:0]);
				end
				"p": begin
					n = $fscanf(fd, "%h %h", f0, f1);
					cpu_drive(f0[15:0], 8'h00, 1'b1);
					@(negedge m2);
					check("prg_addr", prg_addr, f1);
					check("prg_oe", prg_oe, 1);
					check("rom_ce", rom_ce, f0[15]);
				end
				"c": begin
					n = $fscanf(fd, "%h %h %h", f0, f1, f2);
					@(posedge m2);
					#5;
					ppu.addr = f0[13:0];
					ppu.oe   = 1'b0; // a pattern or nametable fetch.
					@(negedge m2);
					check("chr_addr", chr_addr, f1);
					check("ciram_a10", ciram_a10, f2);
					check("ciram_ce", ciram_ce, !f0[13]);
					check("chr_ce", chr_ce, !f0[13]);
					check("chr_oe", chr_oe, 1);
					check("chr_we", chr_we, 0);
				end
				"m": begin
					n = $fscanf(fd, "%h %h %h", f0, f1, f2);
					cpu_drive(f0[15:0], f1[7:0], 1'b0);
					#20; // work ram strobes only while m2 is high.
					check("ram_ce/ram_we", {ram_ce, ram_we}, 2'b11);
					check("srm_addr", srm_addr, f2);
					check("prg_oe", prg_oe, 0);
					check("rom_ce", rom_ce, f0[15]);
					@(posedge m2);
					#5;
					cpu.rw = 1'b1;
				end
				"a": begin
					n = $fscanf(fd, "%h %h", f0, f1);
					axi_write(f0[7:0], f1[7:0]);
				end
				"r": begin
					n = $fscanf(fd, "%h %h", f0, f1);
					axi_read(f0[7:0], f1[7:0]);
				end
				"s": begin
					n = $fscanf(fd, "%h", f0);
					@(posedge m2);
					#5;
					ss_act = f0[0];
				end
				default: begin
					$display("unknown line kind %s in the stimulus file", kind);
					$display("** FAIL **");
					$fatal(1, "bad stimulus file");
				end
			endcase
		end
		$fclose(fd);

		repeat (2) @(posedge m2);
		if (err_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* verification/a53_mapper_assert.sv */
`timescale 1ns/1ps

module a53_mapper_assert (
	input logic              m2,
	input logic              map_rst,
	input a53_pkg::cpu_bus_t cpu,
	input logic              bvalid,
	input logic              bready,
	input logic              rvalid,
	input logic              rready,
	input logic [31:0]       rdata,
	input logic              ram_ce,
	input logic              ram_we
);

	int n_fail = 0;

	a_bvalid_hold: assert property (@(posedge m2) disable iff (map_rst)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			n_fail++;
		end

	a_rvalid_hold: assert property (@(posedge m2) disable iff (map_rst)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin
			$error("read response changed before rready");
			n_fail++;
		end

	// strobes are only live in the high phase of m2.
	a_ram_wr: assert property (@(negedge m2)
		(cpu.ce && !cpu.rw && (cpu.addr[14:13] == 2'b11)) |-> ram_ce && ram_we)
		else begin
			$error("work ram write without ram_ce and ram_we");
			n_fail++;
		end

	a_reset_idle: assert property (@(posedge m2) map_rst |=> !bvalid && !rvalid)
		else begin
			$error("response valid during reset");
			n_fail++;
		end

endmodule

bind a53_mapper a53_mapper_assert u_a53_mapper_assert (
	.m2      (m2),
	.map_rst (map_rst),
	.cpu     (cpu),
	.bvalid  (bvalid),
	.bready  (bready),
	.rvalid  (rvalid),
	.rready  (rready),
	.rdata   (rdata),
	.ram_ce  (ram_ce),
	.ram_we  (ram_we)
);

/* hdl/a53_mapper.sv */
`timescale 1ns/1ps

module a53_mapper #(
	parameter int n_win = 2
) (
	input  logic                       m2,
	input  logic                       map_rst,
	input  logic                       ss_act,
	input  a53_pkg::cpu_bus_t          cpu,
	input  a53_pkg::ppu_bus_t          ppu,
	input  logic [7:0]                 map_idx,
	output logic [a53_pkg::PRG_AW-1:0] prg_addr,
	output logic                       prg_oe,
	output logic                       rom_ce,
	output logic                       ram_ce,
	output logic                       ram_we,
	output logic [12:0]                srm_addr,
	output logic [a53_pkg::CHR_AW-1:0] chr_addr,
	output logic                       chr_ce,
	output logic                       chr_we,
	output logic                       chr_oe,
	output logic                       ciram_a10,
	output logic                       ciram_ce,
	input  logic [31:0]                awaddr,
	input  logic                       awvalid,
	output logic                       awready,
	input  logic [31:0]                wdata,
	input  logic [3:0]                 wstrb,
	input  logic                       wvalid,
	output logic                       wready,
	output logic [1:0]                 bresp,
	output logic                       bvalid,
	input  logic                       bready,
	input  logic [31:0]                araddr,
	input  logic                       arvalid,
	output logic                       arready,
	output logic [31:0]                rdata,
	output logic [1:0]                 rresp,
	output logic                       rvalid,
	input  logic                       rready
);
	import a53_pkg::*;

	a53_regs_t              regs;
	ss_wr_t                 ss_wr;
	logic [n_win-1:0][4:0]  banks;

	a53_regs u_regs (
		.m2      (m2),
		.map_rst (map_rst),
		.cpu     (cpu),
		.ss_act  (ss_act),
		.ss_wr   (ss_wr),
		.regs    (regs)
	);

	// one calculator per 16 KB window.
	for (genvar w = 0; w < n_win; w++) begin : g_win
		prg_window #(
			.win_idx (w)
		) u_prg_window (
			.regs (regs),
			.bank (banks[w])
		);
	end

	a53_addr_mux #(
		.n_win (n_win)
	) u_addr_mux (
		.banks     (banks),
		.regs      (regs),
		.cpu       (cpu),
		.m2        (m2),
		.ppu       (ppu),
		.prg_addr  (prg_addr),
		.prg_oe    (prg_oe),
		.rom_ce    (rom_ce),
		.ram_ce    (ram_ce),
		.ram_we    (ram_we),
		.srm_addr  (srm_addr),
		.chr_addr  (chr_addr),
		.chr_ce    (chr_ce),
		.chr_we    (chr_we),
		.chr_oe    (chr_oe),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce)
	);

	ss_axil_slave u_ss_axil_slave (
		.m2      (m2),
		.map_rst (map_rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.regs    (regs),
		.map_idx (map_idx),
		.ss_wr   (ss_wr)
	);

endmodule

/* hdl/ss_axil_slave.sv */
`timescale 1ns/1ps

module ss_axil_slave (
	input  logic               m2,
	input  logic               map_rst,
	input  logic [31:0]        awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  logic [31:0]        wdata,
	input  logic [3:0]         wstrb,
	input  logic               wvalid,
	output logic               wready,
	output logic [1:0]         bresp,
	output logic               bvalid,
	input  logic               bready,
	input  logic [31:0]        araddr,
	input  logic               arvalid,
	output logic               arready,
	output logic [31:0]        rdata,
	output logic [1:0]         rresp,
	output logic               rvalid,
	input  logic               rready,
	input  a53_pkg::a53_regs_t regs,
	input  logic [7:0]         map_idx,
	output a53_pkg::ss_wr_t    ss_wr
);
	import a53_pkg::*;

	logic       wr_acc;
	logic       rd_acc;
	logic [7:0] rd_byte;

	// --------------------
	// write channel
	// --------------------
	assign wr_acc  = awvalid && wvalid && !bvalid;
	assign awready = wr_acc;
	assign wready  = wr_acc;
	assign bresp   = 2'b00;

	// a cleared low strobe still gets a response but touches nothing.
	assign ss_wr.valid = wr_acc && wstrb[0];
	assign ss_wr.addr  = awaddr[9:2];
	assign ss_wr.data  = wdata[7:0];

	always_ff @(posedge m2) begin
		if (map_rst)
			bvalid <= 1'b0;
		else if (wr_acc)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	// --------------------
	// read channel
	// --------------------
	assign rd_acc  = arvalid && !rvalid;
	assign arready = rd_acc;
	assign rresp   = 2'b00;

	always_comb begin
		case (araddr[9:2])
			SS_INE:  rd_byte = {4'h0, regs.ine_prg};
			SS_OUT:  rd_byte = {2'b00, regs.out_prg};
			SS_MODE: rd_byte = {regs.prg_mode, regs.mirror_mode, regs.prg_size, regs.reg_addr};
			SS_CHR:  rd_byte = {6'd0, regs.chr_ram_bank};
			SS_IDX:  rd_byte = map_idx;
			default: rd_byte = 8'hff;
		endcase
	end

	always_ff @(posedge m2) begin
		if (map_rst)
			rvalid <= 1'b0;
		else if (rd_acc)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge m2) begin
		if (rd_acc)
			rdata <= {24'd0, rd_byte}; // held until the master takes it.
	end

endmodule

/* hdl/a53_addr_mux.sv */
`timescale 1ns/1ps

module a53_addr_mux #(
	parameter int n_win = 2
) (
	input  logic [n_win-1:0][4:0]          banks,
	input  a53_pkg::a53_regs_t             regs,
	input  a53_pkg::cpu_bus_t              cpu,
	input  logic                           m2,
	input  a53_pkg::ppu_bus_t              ppu,
	output logic [a53_pkg::PRG_AW-1:0]     prg_addr,
	output logic                           prg_oe,
	output logic                           rom_ce,
	output logic                           ram_ce,
	output logic                           ram_we,
	output logic [12:0]                    srm_addr,
	output logic [a53_pkg::CHR_AW-1:0]     chr_addr,
	output logic                           chr_ce,
	output logic                           chr_we,
	output logic                           chr_oe,
	output logic                           ciram_a10,
	output logic                           ciram_ce
);
	import a53_pkg::*;

	logic [4:0] bank_sel;

	// with a single window the low calculator serves both halves.
	always_comb begin
		bank_sel = banks[0];
		if (n_win > 1 && cpu.addr[14])
			bank_sel = banks[n_win-1];
	end

	// --------------------
	// cpu side
	// --------------------
	assign prg_addr[12:0]        = cpu.addr[12:0];
	assign prg_addr[13]          = cpu.ce ? 1'b0 : cpu.addr[13];
	assign prg_addr[PRG_AW-1:14] = cpu.ce ? 5'd0 : bank_sel;
	assign prg_oe   = cpu.rw;
	assign rom_ce   = !cpu.ce;
	assign ram_ce   = (cpu.addr[14:13] == 2'b11) && cpu.ce && m2; // $6000-$7FFF.
	assign ram_we   = !cpu.rw && ram_ce;
	assign srm_addr = cpu.addr[12:0];

	// --------------------
	// ppu side
	// --------------------
	assign chr_addr = {regs.chr_ram_bank, ppu.addr[12:0]};
	assign ciram_ce = !ppu.addr[13];
	assign chr_ce   = ciram_ce;
	assign chr_we   = !ppu.we && ciram_ce;
	assign chr_oe   = !ppu.oe;

	always_comb begin
		case (regs.mirror_mode)
			2'b00:   ciram_a10 = 1'b0;
			2'b01:   ciram_a10 = 1'b1;
			2'b10:   ciram_a10 = ppu.addr[10]; // vertical.
			default: ciram_a10 = ppu.addr[11]; // horizontal.
		endcase
	end

endmodule

/* hdl/prg_window.sv */
`timescale 1ns/1ps

module prg_window #(
	parameter int win_idx = 0
) (
	input  a53_pkg::a53_regs_t regs,
	output logic [4:0]         bank
);
	import a53_pkg::*;

	logic [2:0] size_mask;
	logic       fixed;
	logic       win_bit;

	assign win_bit = (win_idx != 0);

	always_comb begin
		case (regs.prg_size)
			2'd0:    size_mask = 3'b000;
			2'd1:    size_mask = 3'b001;
			2'd2:    size_mask = 3'b011;
			default: size_mask = 3'b111;
		endcase
	end

	// mode 2 pins the upper window, mode 3 pins the lower one.
	always_comb begin
		case (regs.prg_mode)
			2'd2:    fixed = win_bit;
			2'd3:    fixed = !win_bit;
			default: fixed = 1'b0;
		endcase
	end

	assign bank[0] = (!regs.prg_mode[1] || fixed) ? win_bit : regs.ine_prg[0];

	// inner bits replace outer bits only where the size mask allows.
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			bank[i+1] = (size_mask[i] && !fixed) ? regs.ine_prg[i+1] : regs.out_prg[i];
		end
	end

	assign bank[4] = regs.out_prg[3];

endmodule

/* hdl/a53_regs.sv */
`timescale 1ns/1ps

module a53_regs (
	input  logic               m2,
	input  logic               map_rst,
	input  a53_pkg::cpu_bus_t  cpu,
	input  logic               ss_act,
	input  a53_pkg::ss_wr_t    ss_wr,
	output a53_pkg::a53_regs_t regs
);
	import a53_pkg::*;

	a53_wdat_u wdat;
	logic      sel_wr;
	logic      rom_wr;

	assign wdat = cpu.dat;

	// select register lives at $5000-$5FFF.
	assign sel_wr = !cpu.rw && cpu.ce && (cpu.addr[14:12] == 3'b101);
	assign rom_wr = !cpu.rw && !cpu.ce;

	always_ff @(posedge m2) begin
		if (map_rst) begin
			regs.ine_prg      <= 4'h0;
			regs.out_prg      <= 6'h1f;
			regs.reg_addr     <= 2'b00;
			regs.prg_size     <= 2'b00;
			regs.mirror_mode  <= 2'b01;
			regs.prg_mode     <= 2'b00;
			regs.chr_ram_bank <= 2'b00;
		end else if (ss_wr.valid) begin
			// --------------------
			// save-state restore
			// --------------------
			case (ss_wr.addr)
				SS_INE:  regs.ine_prg <= ss_wr.data[3:0];
				SS_OUT:  regs.out_prg <= ss_wr.data[5:0];
				SS_MODE: begin
					{regs.prg_mode, regs.mirror_mode, regs.prg_size, regs.reg_addr} <=
						ss_wr.data;
				end
				SS_CHR:  regs.chr_ram_bank <= ss_wr.data[1:0];
				default: regs.reg_addr <= regs.reg_addr; // read-only or unused slot.
			endcase
		end else if (!ss_act) begin
			if (sel_wr) begin
				regs.reg_addr <= {wdat.sel.b7, wdat.sel.b0};
			end else if (rom_wr) begin
				case (regs.reg_addr)
					2'd0: begin
						regs.chr_ram_bank <= wdat.chr.bank;
						if (!regs.mirror_mode[1])
							regs.mirror_mode[0] <= wdat.chr.page; // one-screen page.
					end
					2'd1: begin
						regs.ine_prg <= wdat.inner.bank;
						if (!regs.mirror_mode[1])
							regs.mirror_mode[0] <= wdat.inner.page;
					end
					2'd2: begin
						regs.mirror_mode <= wdat.mode.mirror;
						regs.prg_mode    <= wdat.mode.prg_mode;
						regs.prg_size    <= wdat.mode.size;
					end
					default: begin
						regs.out_prg <= wdat.outer.bank;
					end
				endcase
			end
		end
	end

endmodule

/* hdl/a53_pkg.sv */
package a53_pkg;

	// --------------------
	// bus samples
	// --------------------

	typedef struct packed {
		logic [14:0] addr;
		logic [7:0]  dat;
		logic        rw; // high for a read.
		logic        ce; // high outside $8000-$FFFF.
	} cpu_bus_t;

	typedef struct packed {
		logic [13:0] addr;
		logic        oe; // active low.
		logic        we; // active low.
	} ppu_bus_t;

	typedef struct packed {
		logic [3:0] ine_prg;
		logic [5:0] out_prg;
		logic [1:0] reg_addr;
		logic [1:0] prg_size;
		logic [1:0] mirror_mode;
		logic [1:0] prg_mode;
		logic [1:0] chr_ram_bank;
	} a53_regs_t;

	// --------------------
	// cpu data byte views
	// --------------------

	typedef struct packed {
		logic       b7;
		logic [5:0] rsv;
		logic       b0;
	} wdat_sel_t;

	typedef struct packed {
		logic [2:0] rsv;
		logic       page;
		logic [1:0] rsv_lo;
		logic [1:0] bank;
	} wdat_chr_t;

	typedef struct packed {
		logic [2:0] rsv;
		logic       page;
		logic [3:0] bank;
	} wdat_inner_t;

	typedef struct packed {
		logic [1:0] rsv;
		logic [1:0] size;
		logic [1:0] prg_mode;
		logic [1:0] mirror;
	} wdat_mode_t;

	typedef struct packed {
		logic [1:0] rsv;
		logic [5:0] bank;
	} wdat_outer_t;

	// the meaning of the byte depends on the selected register.
	typedef union packed {
		wdat_sel_t   sel;
		wdat_chr_t   chr;
		wdat_inner_t inner;
		wdat_mode_t  mode;
		wdat_outer_t outer;
	} a53_wdat_u;

	typedef struct packed {
		logic       valid;
		logic [7:0] addr;
		logic [7:0] data;
	} ss_wr_t;

	localparam logic [7:0] SS_INE  = 8'd0;
	localparam logic [7:0] SS_OUT  = 8'd1;
	localparam logic [7:0] SS_MODE = 8'd2;
	localparam logic [7:0] SS_CHR  = 8'd3;
	localparam logic [7:0] SS_IDX  = 8'd127;

	localparam int PRG_AW = 19;
	localparam int CHR_AW = 15;

endpackage
